// File: resampler_pkg.sv
// Shared sizes and constants of the two-channel resampler.
// All widths are fixed here; the RTL modules carry no parameters.
// Coefficients are small so that the sum of TAP_NUM products of a
// full-scale sample fits in ACC_WIDTH without overflow.
// Rate factors are RATE_WIDTH wide, so 1 to 15; a factor of 0 acts as 1.

package resampler_pkg;

    // channels carried side by side in one data word.
    localparam int CH_NUM = 2;

    // signed input sample width per channel.
    localparam int DATA_WIDTH = 16;

    // signed coefficient width.
    localparam int COEF_WIDTH = 18;

    // number of FIR taps.
    localparam int TAP_NUM = 8;

    // filtered word per channel, full product width.
    localparam int ACC_WIDTH = DATA_WIDTH + COEF_WIDTH;

    // width of the interpolation and decimation factor inputs.
    localparam int RATE_WIDTH = 4;

    // symmetric low-pass taps.
    // index 0 multiplies the newest sample.
    localparam logic signed [COEF_WIDTH-1:0] FIR_COEF [TAP_NUM] = '{
        18'sd1,
        -18'sd3,
        18'sd7,
        18'sd20,
        18'sd20,
        18'sd7,
        -18'sd3,
        18'sd1
    };

    // zero-stuffer FSM.
    // IDLE takes a new pair, STUFF issues the zero pairs behind it.
    typedef enum logic {
        IDLE  = 1'b0,
        STUFF = 1'b1
    } interp_state_e;

endpackage

// File: zero_stuffer.sv
// Input stage of the resampler. Takes one sample pair per handshake and
// issues it followed by interp-1 zero pairs, one item per cycle.
// interp_i is expected to stay stable while a pair is being expanded.
// A factor of 0 is handled as 1 here and nowhere else.
// While en_i is low all state holds and tready_o is low.

`timescale 1ns/1ps

module zero_stuffer
    import resampler_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              en_i,

    input  logic                              tvalid_i,
    output logic                              tready_o,
    input  logic [CH_NUM-1:0][DATA_WIDTH-1:0] tdata_i,

    input  logic [RATE_WIDTH-1:0]             interp_i,

    output logic                              up_valid_o,
    output logic [CH_NUM-1:0][DATA_WIDTH-1:0] up_data_o
);

    interp_state_e         state;
    logic [RATE_WIDTH-1:0] factor;
    logic [RATE_WIDTH-1:0] cnt;
    logic                  accept;
    logic                  cnt_done;

    assign factor   = (interp_i == '0) ? RATE_WIDTH'(1) : interp_i;
    assign tready_o = en_i && (state == IDLE);
    assign accept   = tvalid_i && tready_o;

    // cnt holds the number of items issued for the current pair.
    assign cnt_done = (cnt >= factor - RATE_WIDTH'(1));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state      <= IDLE;
            cnt        <= '0;
            up_valid_o <= 1'b0;
        end else if (en_i) begin
            unique case (state)
                IDLE: begin
                    up_valid_o <= accept;
                    if (accept) begin
                        cnt <= RATE_WIDTH'(1);
                        if (factor > RATE_WIDTH'(1)) begin
                            state <= STUFF;
                        end
                    end
                end
                STUFF: begin
                    up_valid_o <= 1'b1;
                    if (cnt_done) begin
                        state <= IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + RATE_WIDTH'(1);
                    end
                end
            endcase
        end
    end

    // sample on accept, zeros while stuffing.
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (accept) begin
                up_data_o <= tdata_i;
            end else if (state == STUFF) begin
                up_data_o <= '0;
            end
        end
    end

endmodule

// File: fir_filter.sv
// Direct-form FIR low-pass, one filter per channel, fixed taps from the
// package. Latency is one cycle from valid_i to valid_o.
// Tap 0 is the incoming sample itself, so only TAP_NUM-1 older samples
// are stored. The delay line moves only on valid_i with en_i high.
// Results wrap in ACC_WIDTH, which the small coefficients never reach.

`timescale 1ns/1ps

module fir_filter
    import resampler_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              en_i,

    input  logic                              valid_i,
    input  logic [CH_NUM-1:0][DATA_WIDTH-1:0] data_i,

    output logic                              valid_o,
    output logic [CH_NUM-1:0][ACC_WIDTH-1:0]  data_o
);

    // stored history, index 0 is the previous sample.
    logic signed [DATA_WIDTH-1:0] hist [CH_NUM][TAP_NUM-1];

    // full tap view including the live input.
    logic signed [DATA_WIDTH-1:0] taps [CH_NUM][TAP_NUM];

    logic signed [ACC_WIDTH-1:0]  mac  [CH_NUM];

    always_comb begin
        for (int c = 0; c < CH_NUM; c++) begin
            taps[c][0] = $signed(data_i[c]);
            for (int k = 1; k < TAP_NUM; k++) begin
                taps[c][k] = hist[c][k-1];
            end
        end
    end

    // multiply-accumulate at full width.
    always_comb begin
        logic signed [ACC_WIDTH-1:0] acc;
        logic signed [ACC_WIDTH-1:0] smp_ext;
        logic signed [ACC_WIDTH-1:0] coef_ext;

        acc      = '0;
        smp_ext  = '0;
        coef_ext = '0;
        for (int c = 0; c < CH_NUM; c++) begin
            acc = '0;
            for (int k = 0; k < TAP_NUM; k++) begin
                smp_ext  = ACC_WIDTH'(taps[c][k]);
                coef_ext = ACC_WIDTH'(FIR_COEF[k]);
                acc      = acc + smp_ext * coef_ext;
            end
            mac[c] = acc;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
            hist    <= '{default: '0};
        end else if (en_i) begin
            valid_o <= valid_i;
            if (valid_i) begin
                for (int c = 0; c < CH_NUM; c++) begin
                    for (int k = 0; k < TAP_NUM - 1; k++) begin
                        hist[c][k] <= taps[c][k];
                    end
                end
            end
        end
    end

    // result register.
    always_ff @(posedge clk_i) begin
        if (en_i && valid_i) begin
            for (int c = 0; c < CH_NUM; c++) begin
                data_o[c] <= mac[c];
            end
        end
    end

endmodule

// File: rate_decimator.sv
// Output stage. Keeps one FIR result in every decim, the first of each
// group, and registers it onto the outputs one cycle later.
// A decimation factor of 0 is handled as 1 here and nowhere else.
// tvalid_o drops while en_i is low; tdata_o holds the last kept result.

`timescale 1ns/1ps

module rate_decimator
    import resampler_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rstn_i,
    input  logic                             en_i,

    input  logic [RATE_WIDTH-1:0]            decim_i,

    input  logic                             valid_i,
    input  logic [CH_NUM-1:0][ACC_WIDTH-1:0] data_i,

    output logic                             tvalid_o,
    output logic [CH_NUM-1:0][ACC_WIDTH-1:0] tdata_o
);

    logic [RATE_WIDTH-1:0] factor;
    logic [RATE_WIDTH-1:0] cnt;
    logic                  keep;

    assign factor = (decim_i == '0) ? RATE_WIDTH'(1) : decim_i;
    assign keep   = valid_i && (cnt == '0);

    // modulo-decim count of incoming results.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt <= '0;
        end else if (en_i && valid_i) begin
            if (cnt >= factor - RATE_WIDTH'(1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + RATE_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tvalid_o <= 1'b0;
        end else begin
            tvalid_o <= en_i && keep;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && keep) begin
            tdata_o <= data_i;
        end
    end

endmodule

// File: resampler_top.sv
// Two-channel sample-rate converter: zero-stuff by interp_i, FIR
// low-pass, keep one result in decim_i.
// Input uses a valid/ready handshake; the output is a plain valid strobe
// with no back-pressure, so the sink must take every result.
// Three cycles from an accepting edge to the matching tvalid_o.
// en_i low freezes the whole chain.

`timescale 1ns/1ps

module resampler_top
    import resampler_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              en_i,

    input  logic                              tvalid_i,
    output logic                              tready_o,
    input  logic [CH_NUM-1:0][DATA_WIDTH-1:0] tdata_i,

    input  logic [RATE_WIDTH-1:0]             interp_i,
    input  logic [RATE_WIDTH-1:0]             decim_i,

    output logic                              tvalid_o,
    output logic [CH_NUM-1:0][ACC_WIDTH-1:0]  tdata_o
);

    logic                              up_valid;
    logic [CH_NUM-1:0][DATA_WIDTH-1:0] up_data;
    logic                              fir_valid;
    logic [CH_NUM-1:0][ACC_WIDTH-1:0]  fir_data;

    zero_stuffer u_stuff (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .en_i      (en_i),
        .tvalid_i  (tvalid_i),
        .tready_o  (tready_o),
        .tdata_i   (tdata_i),
        .interp_i  (interp_i),
        .up_valid_o(up_valid),
        .up_data_o (up_data)
    );

    fir_filter u_fir (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .en_i   (en_i),
        .valid_i(up_valid),
        .data_i (up_data),
        .valid_o(fir_valid),
        .data_o (fir_data)
    );

    rate_decimator u_dec (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .en_i    (en_i),
        .decim_i (decim_i),
        .valid_i (fir_valid),
        .data_i  (fir_data),
        .tvalid_o(tvalid_o),
        .tdata_o (tdata_o)
    );

endmodule

// File: resampler_props.sv
// Concurrent checks on the resampler's top-level ports, bound into
// resampler_top by the testbench.
// The latency check only covers decim_i of 0 or 1, where every FIR
// result is kept, and only when en_i stayed high along the way.

`timescale 1ns/1ps

module resampler_props
    import resampler_pkg::*;
(
    input logic                  clk_i,
    input logic                  rstn_i,
    input logic                  en_i,
    input logic                  tvalid_i,
    input logic                  tready_o,
    input logic [RATE_WIDTH-1:0] decim_i,
    input logic                  tvalid_o
);

    logic accept;

    assign accept = tvalid_i && tready_o && en_i;

    // first edge out of reset.
    reset_state_a: assert property (
        @(posedge clk_i) $rose(rstn_i) |-> !tvalid_o && tready_o
    ) else $error("tvalid_o high or tready_o low on the first edge after reset");

    // an accepted pair leaves three edges later.
    latency_a: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $past(accept, 3) && $past(decim_i <= RATE_WIDTH'(1), 3)
            && $past(en_i, 2) && $past(en_i, 1)
        |-> tvalid_o
    ) else $error("no tvalid_o three cycles after an accepted pair");

    enable_ready_a: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !en_i |-> !tready_o
    ) else $error("tready_o high while en_i is low");

    enable_valid_a: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !en_i |=> !tvalid_o
    ) else $error("tvalid_o high on the edge after en_i was low");

endmodule

// File: tb_resampler.sv
// Testbench for the two-channel resampler.
// Runs bursts of random sample pairs for several interp/decim pairs, with
// a reset before each burst and one enable pause in the middle of each.
// A reference FIR fed from the observed handshakes predicts every kept
// result; outputs are compared in order as they appear.
// Inputs change on the falling edge, the monitor samples on the rising one.

`timescale 1ns/1ps

module tb_resampler
    import resampler_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 3;
    localparam int BURST_NUM     = 6;
    localparam int BURST_LEN     = 24;
    localparam int PAUSE_CYCLES  = 4;
    localparam int DRAIN_CYCLES  = 8;
    localparam int DRAIN_TIMEOUT = 64;

    // rate factors per burst, 0 acts as 1.
    localparam int INTERP_TAB [BURST_NUM] = '{1, 3, 1, 4, 0, 2};
    localparam int DECIM_TAB  [BURST_NUM] = '{1, 1, 3, 2, 0, 5};

    logic                              clk_i = 1'b0;
    logic                              rstn_i;
    logic                              en_i;
    logic                              tvalid_i;
    logic                              tready_o;
    logic [CH_NUM-1:0][DATA_WIDTH-1:0] tdata_i;
    logic [RATE_WIDTH-1:0]             interp_i;
    logic [RATE_WIDTH-1:0]             decim_i;
    logic                              tvalid_o;
    logic [CH_NUM-1:0][ACC_WIDTH-1:0]  tdata_o;

    logic [31:0] rng_state = 32'h2885634a;

    // model state, written by the monitor only.
    logic [CH_NUM*ACC_WIDTH-1:0] exp_q [$];
    longint                      model_hist [CH_NUM][TAP_NUM];
    int                          model_dec_cnt;
    int                          out_count;
    int                          accepted;
    logic                        gap_open;
    int                          gap_len;
    int                          gap_expected;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    resampler_top u_dut (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .en_i    (en_i),
        .tvalid_i(tvalid_i),
        .tready_o(tready_o),
        .tdata_i (tdata_i),
        .interp_i(interp_i),
        .decim_i (decim_i),
        .tvalid_o(tvalid_o),
        .tdata_o (tdata_o)
    );

    bind resampler_top resampler_props u_props (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .en_i    (en_i),
        .tvalid_i(tvalid_i),
        .tready_o(tready_o),
        .decim_i (decim_i),
        .tvalid_o(tvalid_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;

        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int eff_factor(input logic [RATE_WIDTH-1:0] f);
        return (f == '0) ? 1 : int'(f);
    endfunction

    function automatic int stuffed_items();
        int n;

        n = 0;
        for (int b = 0; b < BURST_NUM; b++) begin
            n += BURST_LEN * eff_factor(RATE_WIDTH'(INTERP_TAB[b]));
        end
        return n;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    // sample in -4096..4096.
    task automatic next_sample(output logic [DATA_WIDTH-1:0] s);
        int v;

        rng_state = xorshift32(rng_state);
        v = int'(rng_state % 32'd8193) - 4096;
        s = DATA_WIDTH'(v);
    endtask

    // one item of the stuffed stream through the model FIR and decimator.
    task automatic model_item(input logic [CH_NUM-1:0][DATA_WIDTH-1:0] pair);
        logic [CH_NUM-1:0][ACC_WIDTH-1:0] res;
        longint                           sum;

        for (int c = 0; c < CH_NUM; c++) begin
            for (int k = TAP_NUM - 1; k > 0; k--) begin
                model_hist[c][k] = model_hist[c][k-1];
            end
            model_hist[c][0] = longint'($signed(pair[c]));
            sum = 64'sd0;
            for (int k = 0; k < TAP_NUM; k++) begin
                sum += longint'(FIR_COEF[k]) * model_hist[c][k];
            end
            res[c] = sum[ACC_WIDTH-1:0];
        end
        if (model_dec_cnt == 0) begin
            exp_q.push_back(res);
        end
        model_dec_cnt = (model_dec_cnt + 1) % eff_factor(decim_i);
    endtask

    always @(posedge clk_i) begin : monitor
        logic [CH_NUM*ACC_WIDTH-1:0] exp_word;
        int                          f;

        if (!rstn_i) begin
            exp_q.delete();
            for (int c = 0; c < CH_NUM; c++) begin
                for (int k = 0; k < TAP_NUM; k++) begin
                    model_hist[c][k] = 64'sd0;
                end
            end
            model_dec_cnt = 0;
            out_count     = 0;
            accepted      = 0;
            gap_open      = 1'b0;
            gap_len       = 0;
            gap_expected  = 0;
        end else begin
            if (tvalid_o) begin
                assert (exp_q.size() > 0)
                    else report_failure("tvalid_o pulsed while the model expected no result");
                exp_word = exp_q.pop_front();
                assert (tdata_o == exp_word)
                    else report_failure($sformatf("[ERROR] tdata_o expected 0x%h actual 0x%h",
                                                  exp_word, tdata_o));
                out_count++;
            end
            // ready returns after interp-1 enabled cycles.
            if (gap_open) begin
                if (tready_o) begin
                    assert (gap_len == gap_expected)
                        else report_failure($sformatf(
                            "[ERROR] tready_o low cycles expected 0x%h actual 0x%h",
                            gap_expected, gap_len));
                    gap_open = 1'b0;
                end else if (en_i) begin
                    gap_len++;
                end
            end
            if (tvalid_i && tready_o && en_i) begin
                f = eff_factor(interp_i);
                accepted++;
                model_item(tdata_i);
                for (int z = 1; z < f; z++) begin
                    model_item('0);
                end
                gap_open     = 1'b1;
                gap_len      = 0;
                gap_expected = f - 1;
            end
        end
    end

    task automatic apply_reset(input logic [RATE_WIDTH-1:0] interp,
                               input logic [RATE_WIDTH-1:0] decim);
        @(negedge clk_i);
        rstn_i   = 1'b0;
        tvalid_i = 1'b0;
        interp_i = interp;
        decim_i  = decim;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;
    endtask

    // holds the pair until the edge that takes it.
    task automatic send_pair();
        logic [CH_NUM-1:0][DATA_WIDTH-1:0] pair;
        logic [DATA_WIDTH-1:0]             s;

        for (int c = 0; c < CH_NUM; c++) begin
            next_sample(s);
            pair[c] = s;
        end
        if (rng_state[3:0] == 4'd0) begin
            @(negedge clk_i);
        end
        tvalid_i = 1'b1;
        tdata_i  = pair;
        while (!tready_o) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        tvalid_i = 1'b0;
    endtask

    task automatic pause_enable(input int cycles);
        en_i = 1'b0;
        repeat (cycles) @(negedge clk_i);
        en_i = 1'b1;
        @(negedge clk_i);
    endtask

    // output count from the rate rule, waited for with a bound.
    task automatic drain_and_check();
        int expected_outs;
        int waited;

        expected_outs = (accepted * eff_factor(interp_i) + eff_factor(decim_i) - 1)
                        / eff_factor(decim_i);
        waited = 0;
        while (out_count < expected_outs && waited < DRAIN_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        repeat (DRAIN_CYCLES) @(negedge clk_i);
        assert (out_count == expected_outs)
            else report_failure($sformatf("[ERROR] tvalid_o count expected 0x%h actual 0x%h",
                                          expected_outs, out_count));
    endtask

    initial begin
        rstn_i   = 1'b0;
        en_i     = 1'b1;
        tvalid_i = 1'b0;
        tdata_i  = '0;
        interp_i = RATE_WIDTH'(1);
        decim_i  = RATE_WIDTH'(1);
        for (int b = 0; b < BURST_NUM; b++) begin
            apply_reset(RATE_WIDTH'(INTERP_TAB[b]), RATE_WIDTH'(DECIM_TAB[b]));
            for (int i = 0; i < BURST_LEN; i++) begin
                send_pair();
                if (i == BURST_LEN / 2) begin
                    pause_enable(PAUSE_CYCLES);
                end
            end
            drain_and_check();
        end
        $display("Done: no errors");
        $finish;
    end

    // 20 cycles per stuffed item, plus reset, pause and drain per burst.
    initial begin : watchdog
        int limit;

        limit = stuffed_items() * 20 + BURST_NUM * 100;
        #(limit * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the bursts finished", limit);
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule

// File: src.f
resampler_pkg.sv
zero_stuffer.sv
fir_filter.sv
rate_decimator.sv
resampler_top.sv
resampler_props.sv
tb_resampler.sv

// File: run.sh
#!/bin/sh
# Builds the resampler testbench with Verilator and runs it.
# Exits non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_resampler \
    -f src.f \
    -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_resampler
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation exited cleanly"
exit 0
